//--- include/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// widths
`define CORE_DATA_W 8
`define CORE_ADDR_W 16
`define CORE_STEP_W 3

// first fetch after reset
`define CORE_RESET_PC 16'hC000

// cc field, opcode group
`define CORE_GRP_CC0 2'b00
`define CORE_GRP_CC1 2'b01
`define CORE_GRP_CC2 2'b10
`define CORE_GRP_CC3 2'b11

// aaa field, operation within a group
`define CORE_GRP_ORA 3'b000
`define CORE_GRP_AND 3'b001
`define CORE_GRP_EOR 3'b010
`define CORE_GRP_ADC 3'b011
`define CORE_GRP_STA 3'b100
`define CORE_GRP_LDA 3'b101
`define CORE_GRP_CMP 3'b110
`define CORE_GRP_SBC 3'b111

// bbb field, addressing modes in use
`define CORE_MODE_ZP     3'b001
`define CORE_MODE_IMM    3'b010
`define CORE_MODE_IMM_XY 3'b000

// single opcodes, matched on the flat byte
`define CORE_OP_JMP 8'h4C
`define CORE_OP_TAX 8'hAA
`define CORE_OP_INX 8'hE8
`define CORE_OP_INY 8'hC8
`define CORE_OP_DEX 8'hCA
`define CORE_OP_CLC 8'h18
`define CORE_OP_SEC 8'h38
`define CORE_OP_BEQ 8'hF0
`define CORE_OP_BNE 8'hD0
`define CORE_OP_BCC 8'h90
`define CORE_OP_BCS 8'hB0

`endif

//--- source/core_pkg.sv
`include "core_macros.svh"

package core_pkg;

    // sequencer phase
    typedef enum logic [1:0] {
        PHASE_FETCH   = 2'b00,
        PHASE_DECODE  = 2'b01,
        PHASE_NEITHER = 2'b10
    } core_phase_t;

    typedef enum logic [2:0] {
        ALU_HOLD,
        ALU_PASS,
        ALU_ADD,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_INC,
        ALU_DEC
    } core_alu_op_t;

    // register written back from the alu result
    typedef enum logic [1:0] {
        DST_A,
        DST_X,
        DST_Y,
        DST_NONE
    } core_dst_t;

    // 6502 field view of an opcode, aaa bbb cc
    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } core_opcode_fields_t;

    typedef union packed {
        logic [`CORE_DATA_W-1:0] flat;
        core_opcode_fields_t     f;
    } core_opcode_u;

endpackage : core_pkg

//--- source/core_sequencer.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module core_sequencer import core_pkg::*; (
    input  logic                    clock,
    input  logic                    i_rst_n,
    input  logic                    i_clock_en,
    input  logic [`CORE_DATA_W-1:0] i_r_data,
    input  logic                    i_z_flag,
    input  logic                    i_c_flag,
    output core_phase_t             o_phase,
    output core_opcode_u            o_opcode,
    output logic [`CORE_STEP_W-1:0] o_step,
    output logic [`CORE_ADDR_W-1:0] o_pc,
    output logic                    o_operand_valid,
    output logic                    o_store_addr,
    output logic                    o_store_en
);

    logic [`CORE_DATA_W-1:0] operand_q;
    core_phase_t             next_phase;
    logic                    is_imm, is_store, is_jmp, is_branch;
    logic                    taken, done;

    ////////////////////
    // per-group decode

    always_comb begin
        is_imm = (o_opcode.f.cc == `CORE_GRP_CC1 && o_opcode.f.bbb == `CORE_MODE_IMM &&
                  o_opcode.f.aaa != `CORE_GRP_STA) ||
                 ((o_opcode.f.cc == `CORE_GRP_CC0 || o_opcode.f.cc == `CORE_GRP_CC2) &&
                  o_opcode.f.bbb == `CORE_MODE_IMM_XY && o_opcode.f.aaa == `CORE_GRP_LDA);
        is_store = o_opcode.f.bbb == `CORE_MODE_ZP && o_opcode.f.aaa == `CORE_GRP_STA &&
                   o_opcode.f.cc != `CORE_GRP_CC3;
        is_jmp = o_opcode.flat == `CORE_OP_JMP;
    end

    // branch condition on the flat byte
    always_comb begin
        is_branch = 1'b1;
        taken = 1'b0;
        case (o_opcode.flat)
            `CORE_OP_BEQ: taken = i_z_flag;
            `CORE_OP_BNE: taken = ~i_z_flag;
            `CORE_OP_BCS: taken = i_c_flag;
            `CORE_OP_BCC: taken = ~i_c_flag;
            default:      is_branch = 1'b0;
        endcase
    end

    // taken branch spends one extra step
    assign done = is_store || is_jmp || (is_branch && (o_step != '0 || !taken));

    assign o_operand_valid = o_phase == PHASE_DECODE && is_imm;
    assign o_store_addr = o_phase == PHASE_DECODE && is_store;
    assign o_store_en = o_phase == PHASE_NEITHER && is_store;

    ////////////////////
    // phase machine

    always_comb begin
        next_phase = PHASE_FETCH;
        case (o_phase)
            PHASE_FETCH:  next_phase = PHASE_DECODE;
            PHASE_DECODE: begin
                if (is_store || is_jmp || is_branch) begin
                    next_phase = PHASE_NEITHER;
                end
            end
            PHASE_NEITHER: next_phase = done ? PHASE_FETCH : PHASE_NEITHER;
            default:       next_phase = PHASE_FETCH;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            o_phase <= PHASE_FETCH;
            o_step <= '0;
            o_pc <= `CORE_RESET_PC;
        end else if (i_clock_en) begin
            o_phase <= next_phase;
            o_step <= (o_phase == PHASE_NEITHER) ? o_step + 1'b1 : '0;
            case (o_phase)
                PHASE_FETCH: o_pc <= o_pc + 1'b1;
                PHASE_DECODE: begin
                    // unknown opcodes leave the pc alone
                    if (is_imm || is_store || is_jmp || is_branch) begin
                        o_pc <= o_pc + 1'b1;
                    end
                end
                PHASE_NEITHER: begin
                    if (is_jmp) begin
                        o_pc <= {i_r_data, operand_q};
                    end else if (is_branch && taken && o_step == '0) begin
                        o_pc <= o_pc + {{8{operand_q[7]}}, operand_q};
                    end
                end
                default: o_pc <= o_pc;
            endcase
        end
    end

    // opcode at fetch, first operand byte at decode
    always_ff @(posedge clock) begin
        if (i_clock_en) begin
            if (o_phase == PHASE_FETCH) begin
                o_opcode <= i_r_data;
            end
            if (o_phase == PHASE_DECODE) begin
                operand_q <= i_r_data;
            end
        end
    end

    // neither phase lasts two steps at most
    a_step_bound: assert property (@(posedge clock) disable iff (!i_rst_n)
        o_phase == PHASE_NEITHER |-> o_step <= 1);

endmodule : core_sequencer

//--- source/core_execute.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module core_execute import core_pkg::*; (
    input  logic                    clock,
    input  logic                    i_rst_n,
    input  logic                    i_clock_en,
    input  logic [`CORE_DATA_W-1:0] i_r_data,
    input  core_phase_t             i_phase,
    input  core_opcode_u            i_opcode,
    input  logic                    i_operand_valid,
    output logic                    o_z_flag,
    output logic                    o_c_flag,
    output logic                    o_n_flag,
    output logic                    o_v_flag,
    output logic [`CORE_DATA_W-1:0] o_store_data
);

    logic [`CORE_DATA_W-1:0] a, x, y;
    core_alu_op_t            alu_op;
    core_dst_t               dst, dst_q;
    logic [`CORE_DATA_W-1:0] src1, src2, src2_eff, alu_res, alu_out;
    logic                    src2_inv, c_in, c_res, v_res;
    logic                    upd_v, upd_c;
    logic                    upd_v_q, upd_c_q;
    logic                    alu_c_out, alu_v_out, alu_z_out, alu_n_out;
    logic                    wb_pending, a_we, x_we, y_we;

    ////////////////////
    // decode

    always_comb begin
        alu_op = ALU_HOLD;
        dst = DST_NONE;
        src1 = a;
        src2 = i_r_data;
        src2_inv = 1'b0;
        c_in = 1'b0;
        upd_v = 1'b0;
        upd_c = 1'b0;
        if (i_operand_valid) begin
            case (i_opcode.f.cc)
                `CORE_GRP_CC1: begin
                    dst = DST_A;
                    case (i_opcode.f.aaa)
                        `CORE_GRP_ORA: alu_op = ALU_OR;
                        `CORE_GRP_AND: alu_op = ALU_AND;
                        `CORE_GRP_EOR: alu_op = ALU_XOR;
                        `CORE_GRP_LDA: alu_op = ALU_PASS;
                        `CORE_GRP_CMP: begin
                            // subtract with borrow clear and drop the result
                            alu_op = ALU_ADD;
                            dst = DST_NONE;
                            src2_inv = 1'b1;
                            c_in = 1'b1;
                            upd_c = 1'b1;
                        end
                        default: begin
                            // ADC and SBC as ADC of the inverted operand
                            alu_op = ALU_ADD;
                            src2_inv = i_opcode.f.aaa == `CORE_GRP_SBC;
                            c_in = o_c_flag;
                            upd_v = 1'b1;
                            upd_c = 1'b1;
                        end
                    endcase
                end
                `CORE_GRP_CC2: begin
                    alu_op = ALU_PASS;
                    dst = DST_X;
                end
                default: begin
                    alu_op = ALU_PASS;
                    dst = DST_Y;
                end
            endcase
        end else if (i_phase == PHASE_DECODE) begin
            case (i_opcode.flat)
                `CORE_OP_INX: begin
                    alu_op = ALU_INC;
                    src1 = x;
                    dst = DST_X;
                end
                `CORE_OP_DEX: begin
                    alu_op = ALU_DEC;
                    src1 = x;
                    dst = DST_X;
                end
                `CORE_OP_INY: begin
                    alu_op = ALU_INC;
                    src1 = y;
                    dst = DST_Y;
                end
                `CORE_OP_TAX: begin
                    alu_op = ALU_PASS;
                    src2 = a;
                    dst = DST_X;
                end
                default: alu_op = ALU_HOLD;
            endcase
        end
    end

    ////////////////////
    // alu

    assign src2_eff = src2_inv ? ~src2 : src2;

    always_comb begin
        c_res = 1'b0;
        v_res = 1'b0;
        case (alu_op)
            ALU_ADD: begin
                {c_res, alu_res} = src1 + src2_eff + c_in;
                v_res = (src1[7] == src2_eff[7]) && (alu_res[7] != src1[7]);
            end
            ALU_AND: alu_res = src1 & src2;
            ALU_OR:  alu_res = src1 | src2;
            ALU_XOR: alu_res = src1 ^ src2;
            ALU_INC: alu_res = src1 + 1'b1;
            ALU_DEC: alu_res = src1 - 1'b1;
            default: alu_res = src2;
        endcase
    end

    // result and its flags load only when the alu is busy
    always_ff @(posedge clock) begin
        if (i_clock_en && alu_op != ALU_HOLD) begin
            alu_out <= alu_res;
            alu_c_out <= c_res;
            alu_v_out <= v_res;
            alu_z_out <= alu_res == '0;
            alu_n_out <= alu_res[7];
            dst_q <= dst;
            upd_v_q <= upd_v;
            upd_c_q <= upd_c;
        end
    end

    ////////////////////
    // write back one cycle after the alu

    assign a_we = wb_pending && dst_q == DST_A;
    assign x_we = wb_pending && dst_q == DST_X;
    assign y_we = wb_pending && dst_q == DST_Y;

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            wb_pending <= 1'b0;
            a <= '0;
            x <= '0;
            y <= '0;
            {o_n_flag, o_v_flag, o_z_flag, o_c_flag} <= 4'b0;
        end else if (i_clock_en) begin
            wb_pending <= alu_op != ALU_HOLD;
            if (a_we) a <= alu_out;
            if (x_we) x <= alu_out;
            if (y_we) y <= alu_out;
            if (wb_pending) begin
                o_n_flag <= alu_n_out;
                o_z_flag <= alu_z_out;
            end
            if (wb_pending && upd_v_q) o_v_flag <= alu_v_out;
            if (wb_pending && upd_c_q) begin
                o_c_flag <= alu_c_out;
            end else if (i_phase == PHASE_DECODE && i_opcode.flat == `CORE_OP_CLC) begin
                o_c_flag <= 1'b0;
            end else if (i_phase == PHASE_DECODE && i_opcode.flat == `CORE_OP_SEC) begin
                o_c_flag <= 1'b1;
            end
        end
    end

    // store source follows the cc field of STA, STX and STY
    always_comb begin
        case (i_opcode.f.cc)
            `CORE_GRP_CC1: o_store_data = a;
            `CORE_GRP_CC2: o_store_data = x;
            default:       o_store_data = y;
        endcase
    end

    // alu works only on decode cycles and writes back in the next fetch
    a_alu_decode: assert property (@(posedge clock) disable iff (!i_rst_n)
        i_clock_en && alu_op != ALU_HOLD |-> i_phase == PHASE_DECODE);

endmodule : core_execute

//--- source/core_bus.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module core_bus import core_pkg::*; (
    input  logic                    clock,
    input  logic                    i_rst_n,
    input  logic                    i_clock_en,
    input  logic [`CORE_DATA_W-1:0] i_r_data,
    input  core_phase_t             i_phase,
    input  logic [`CORE_ADDR_W-1:0] i_pc,
    input  logic                    i_store_addr,
    input  logic                    i_store_en,
    input  logic [`CORE_DATA_W-1:0] i_store_data,
    output logic [`CORE_ADDR_W-1:0] o_addr,
    output logic                    o_mem_r_en,
    output logic                    o_mem_w_en,
    output logic [`CORE_DATA_W-1:0] o_w_data
);

    logic [`CORE_ADDR_W-1:0] addr_q, next_addr;
    logic [`CORE_DATA_W-1:0] r_data_buffer, w_data_q;
    logic                    store_cycle;

    assign store_cycle = i_store_en && i_phase == PHASE_NEITHER;

    // zero page store with the high byte zero
    assign next_addr = store_cycle ? {8'h00, r_data_buffer} : i_pc;

    assign o_mem_r_en = ~store_cycle;
    assign o_mem_w_en = i_clock_en && store_cycle;

    // address and write data pass straight through on an enabled cycle
    assign o_addr = i_clock_en ? next_addr : addr_q;
    assign o_w_data = (i_clock_en && store_cycle) ? i_store_data : w_data_q;

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            addr_q <= `CORE_RESET_PC;
        end else if (i_clock_en) begin
            addr_q <= next_addr;
        end
    end

    always_ff @(posedge clock) begin
        if (i_clock_en && i_store_addr && o_mem_r_en) begin
            r_data_buffer <= i_r_data;
        end
        if (i_clock_en && store_cycle) begin
            w_data_q <= i_store_data;
        end
    end

    // store cycle follows its address byte or a stall
    a_w_after_addr: assert property (@(posedge clock) disable iff (!i_rst_n)
        o_mem_w_en |-> $past(i_store_addr || !i_clock_en));

endmodule : core_bus

//--- source/core.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module core import core_pkg::*; (
    input  logic                    clock,
    input  logic                    i_rst_n,
    input  logic                    i_clock_en,
    input  logic [`CORE_DATA_W-1:0] i_r_data,
    output logic [`CORE_ADDR_W-1:0] o_addr,
    output logic                    o_mem_r_en,
    output logic                    o_mem_w_en,
    output logic [`CORE_DATA_W-1:0] o_w_data
);

    core_phase_t             phase;
    core_opcode_u            opcode;
    logic [`CORE_ADDR_W-1:0] pc;
    logic [`CORE_DATA_W-1:0] store_data;
    logic                    operand_valid, store_addr, store_en;
    logic                    z_flag, c_flag;

    core_sequencer u_sequencer (
        .clock(clock), .i_rst_n(i_rst_n), .i_clock_en(i_clock_en),
        .i_r_data(i_r_data), .i_z_flag(z_flag), .i_c_flag(c_flag),
        .o_phase(phase), .o_opcode(opcode), .o_step(), .o_pc(pc),
        .o_operand_valid(operand_valid), .o_store_addr(store_addr),
        .o_store_en(store_en));

    core_execute u_execute (
        .clock(clock), .i_rst_n(i_rst_n), .i_clock_en(i_clock_en),
        .i_r_data(i_r_data), .i_phase(phase), .i_opcode(opcode),
        .i_operand_valid(operand_valid), .o_z_flag(z_flag), .o_c_flag(c_flag),
        .o_n_flag(), .o_v_flag(), .o_store_data(store_data));

    core_bus u_bus (
        .clock(clock), .i_rst_n(i_rst_n), .i_clock_en(i_clock_en),
        .i_r_data(i_r_data), .i_phase(phase), .i_pc(pc),
        .i_store_addr(store_addr), .i_store_en(store_en), .i_store_data(store_data),
        .o_addr(o_addr), .o_mem_r_en(o_mem_r_en), .o_mem_w_en(o_mem_w_en),
        .o_w_data(o_w_data));

endmodule : core

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic o_clock,
    output logic o_rst_n
);

    localparam int half_period = 5;
    localparam int reset_cycles = 3;

    initial begin
        o_clock = 1'b0;
        forever #(half_period) o_clock = ~o_clock;
    end

    // released just after an edge, like the other inputs
    initial begin
        o_rst_n = 1'b0;
        repeat (reset_cycles) @(posedge o_clock);
        #1;
        o_rst_n = 1'b1;
    end

endmodule : tb_clock

//--- test/core_tb.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module core_tb;

    logic                    clock, rst_n, clock_en;
    logic [`CORE_DATA_W-1:0] r_data, w_data;
    logic [`CORE_ADDR_W-1:0] addr;
    logic                    mem_r_en, mem_w_en;

    logic [7:0]  mem [0:65535];
    logic [15:0] exp_addr [0:255];
    logic [7:0]  exp_data [0:255];
    int          prog_len, write_count, writes_seen, errors, limit;
    bit          reset_checked = 1'b0;

    tb_clock u_clock (.o_clock(clock), .o_rst_n(rst_n));

    core u_dut (
        .clock(clock),
        .i_rst_n(rst_n),
        .i_clock_en(clock_en),
        .i_r_data(r_data),
        .o_addr(addr),
        .o_mem_r_en(mem_r_en),
        .o_mem_w_en(mem_w_en),
        .o_w_data(w_data)
    );

    // memory answers straight from the address bus
    assign r_data = mem[addr];

    ////////////////////
    // helpers

    task automatic load_vectors;
        int i;
        for (i = 0; i < 65536; i++) begin
            mem[i] = i[15:8] ^ i[7:0];
        end
        $readmemh("test/core_vectors.txt", mem);
        // header at E000 followed by one address and data triple per write
        prog_len = mem[16'hE000];
        write_count = mem[16'hE001];
        for (i = 0; i < write_count; i++) begin
            exp_addr[i] = {mem[16'hE002 + 3 * i], mem[16'hE003 + 3 * i]};
            exp_data[i] = mem[16'hE004 + 3 * i];
        end
    endtask

    task automatic check_reset_state;
        if (addr !== `CORE_RESET_PC) begin
            errors++;
            $display("FAIL %0t: o_addr expected %h got %h", $time, `CORE_RESET_PC, addr);
        end
        if (mem_r_en !== 1'b1) begin
            errors++;
            $display("FAIL %0t: o_mem_r_en expected 1 got %b", $time, mem_r_en);
        end
        if (mem_w_en !== 1'b0) begin
            errors++;
            $display("FAIL %0t: o_mem_w_en expected 0 got %b", $time, mem_w_en);
        end
    endtask

    task automatic check_write;
        if (writes_seen >= write_count) begin
            errors++;
            $display("unexpected write of %h to address %h at %0t after the last expected write",
                     w_data, addr, $time);
        end else begin
            if (addr !== exp_addr[writes_seen]) begin
                errors++;
                $display("FAIL %0t: o_addr expected %h got %h", $time,
                         exp_addr[writes_seen], addr);
            end
            if (w_data !== exp_data[writes_seen]) begin
                errors++;
                $display("FAIL %0t: o_w_data expected %h got %h", $time,
                         exp_data[writes_seen], w_data);
            end
            if (mem_r_en !== 1'b0) begin
                errors++;
                $display("FAIL %0t: o_mem_r_en expected 0 got %b", $time, mem_r_en);
            end
            writes_seen++;
        end
    endtask

    task automatic finish_run;
        $display("writes seen: %0d of %0d, errors: %0d", writes_seen, write_count, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    ////////////////////
    // stimulus and checks

    initial begin
        clock_en = 1'b1;
        errors = 0;
        writes_seen = 0;
        load_vectors();
        void'($urandom(32'hb798));
        @(posedge rst_n);
        wait (writes_seen == write_count);
        // a few more cycles to catch stray writes
        repeat (20) @(posedge clock);
        finish_run();
    end

    // clock enable about three quarters high
    initial begin
        @(posedge rst_n);
        forever begin
            @(posedge clock);
            #1;
            clock_en = ($urandom % 4) != 0;
        end
    end

    // outputs sampled mid cycle where they are stable
    always @(negedge clock) begin
        if (rst_n && !reset_checked) begin
            check_reset_state();
            reset_checked = 1'b1;
        end
        if (rst_n && !clock_en && mem_w_en) begin
            errors++;
            $display("write strobe to address %h at %0t while the clock enable is low",
                     addr, $time);
        end
        if (rst_n && clock_en && mem_w_en) begin
            check_write();
            mem[addr] = w_data;
        end
    end

    initial begin
        @(posedge rst_n);
        limit = prog_len * 40 * 2;
        repeat (limit) @(posedge clock);
        errors++;
        $display("timeout: write %0d of %0d never came within %0d cycles",
                 writes_seen + 1, write_count, limit);
        finish_run();
    end

endmodule : core_tb

//--- project.f
+incdir+include
source/core_pkg.sv
source/core_sequencer.sv
source/core_execute.sv
source/core_bus.sv
source/core.sv
test/tb_clock.sv
test/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module core_tb -f project.f -o core_sim \
    && ./obj_dir/core_sim | tee sim.log \
    && grep -qx "No errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- test/core_vectors.txt
// program image at C000, hex bytes in address order
// E000 program length, E001 write count, then address high, address low, data per write
@C000
A9 5A 85 10 A2 3C 86 11 A0 C3 84 12 18 A9 37 69
25 85 13 38 69 A0 85 14 38 E9 0E 85 15 E9 F0 85
16 A9 7F 18 69 01 85 17 69 80 69 00 85 18 A9 F0
29 3C 09 05 85 19 49 FF 85 1A C9 CA F0 02 85 1B
C9 CB B0 02 85 1C C9 10 90 02 85 1D A0 FE C8 C8
84 1E A9 41 AA E8 86 1F A2 03 86 20 CA D0 FB 86
21 4C 68 C0 85 22 EA EA EA A9 99 85 23 4C 6D C0
@E000
70 14
00 10 5A 00 11 3C 00 12 C3 00 13 5C 00 14 FD
00 15 EF 00 16 FF 00 17 80 00 18 01 00 19 35
00 1A CA 00 1C CA 00 1D CA 00 1E 00 00 1F 42
00 20 03 00 20 02 00 20 01 00 21 00 00 23 99
